//--- sysctl_top.f
+incdir+design
design/sysctl_bus_pkg.sv
design/sysctl_board_pkg.sv
design/sysctl_bus_if.sv
design/epb_bridge.sv
design/sysctl_regs.sv
design/reset_led_ctrl.sv
design/sysctl_top.sv
tb/sysctl_properties.sv
tb/sysctl_tb.sv

//--- tb/sysctl_tb.sv
`timescale 1ns/1ps
`include "sysctl_macros.svh"

module sysctl_tb import sysctl_bus_pkg::*, sysctl_board_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int N_ACCESS     = 67; // 8 rev + 24 rw + 30 ro + 2 reset + 3 por

  localparam logic [15:0] EXP_ID  = `SYSCTL_DESIGN_ID;
  localparam logic [15:0] EXP_RCS = `SYSCTL_REV_RCS;

  // shadow registers plus the board inputs currently driven
  typedef struct packed {
    logic [1:0] user_led;
    logic [1:0] control;
    logic [7:0] scratch;
    logic [7:0] sys_config;
    logic [3:0] user_dip;
    logic [3:0] config_dip;
    logic       flash_busy_n;
    logic       syserr;
  } model_t;

  logic clk_master;
  logic reset_mon;
  logic epb_cs_n;
  logic epb_we_n;
  logic epb_oen_n;
  logic [SYSCTL_AW-1:0] epb_addr;
  logic [SYSCTL_DW-1:0] epb_wdata;
  logic [SYSCTL_DW-1:0] epb_rdata;
  logic epb_data_oe;
  logic epb_rdy;
  logic reset_por_n;
  logic reset_debug_n;
  logic v5c_done;
  logic ppc_reset_n;
  logic ppc_ddr2_reset_n;
  logic geth_reset_n;
  logic por_force;
  logic [1:0] sys_led_n;
  logic [1:0] user_led_n;
  logic [2:0] boot_conf;
  model_t mdl;

  string      name_q[$];
  logic [7:0] exp_q[$];
  logic [7:0] act_q[$];
  int n_checks  = 0;
  int val_errs  = 0;
  int other_errs = 0;

  sysctl_top DUT (
    .clk_master         (clk_master),
    .reset_mon          (reset_mon),
    .epb_cs_n_i         (epb_cs_n),
    .epb_we_n_i         (epb_we_n),
    .epb_oen_n_i        (epb_oen_n),
    .epb_addr_i         (epb_addr),
    .epb_data_i         (epb_wdata),
    .epb_data_o         (epb_rdata),
    .epb_data_oe_o      (epb_data_oe),
    .epb_rdy_o          (epb_rdy),
    .reset_por_n_i      (reset_por_n),
    .reset_debug_n_i    (reset_debug_n),
    .sys_config_i       (mdl.sys_config),
    .user_dip_i         (mdl.user_dip),
    .config_dip_i       (mdl.config_dip),
    .flash_busy_n_i     (mdl.flash_busy_n),
    .ppc_syserr_i       (mdl.syserr),
    .v5c_done_i         (v5c_done),
    .ppc_reset_n_o      (ppc_reset_n),
    .ppc_ddr2_reset_n_o (ppc_ddr2_reset_n),
    .geth_reset_n_o     (geth_reset_n),
    .por_force_o        (por_force),
    .sys_led_n_o        (sys_led_n),
    .user_led_n_o       (user_led_n),
    .boot_conf_o        (boot_conf)
  );

  initial begin
    clk_master = 1'b0;
    forever #(CLK_PERIOD / 2) clk_master = ~clk_master;
  end

  function automatic logic [7:0] ref_read(input logic [4:0] adr, input model_t m);
    logic [7:0] rd;
    rd = 8'h00;
    if (adr[4:3] == 2'd3) begin
      case (adr[2:0])
        3'd0:    rd = EXP_ID[15:8];
        3'd1:    rd = EXP_ID[7:0];
        3'd2:    rd = `SYSCTL_REV_MAJOR;
        3'd3:    rd = `SYSCTL_REV_MINOR;
        3'd4:    rd = EXP_RCS[15:8];
        3'd5:    rd = EXP_RCS[7:0];
        default: rd = 8'h00;
      endcase
    end else if (adr[4:3] == 2'd0) begin
      case (reg_idx_e'(adr[2:0]))
        reg_user_led:   rd = {6'b0, m.user_led};
        reg_control:    rd = {6'b0, m.control};
        reg_sys_config: rd = m.sys_config;
        reg_dips:       rd = {m.user_dip, m.config_dip};
        reg_status:     rd = {6'b0, m.syserr, !m.flash_busy_n};
        reg_scratch:    rd = m.scratch;
        default:        rd = 8'h00;
      endcase
    end
    return rd; // banks 1 and 2 read 0
  endfunction

  function automatic model_t ref_write(input model_t m, input logic [4:0] adr,
                                       input logic [7:0] d);
    model_t r;
    r = m;
    if (adr[4:3] == 2'd0) begin
      case (reg_idx_e'(adr[2:0]))
        reg_user_led: r.user_led = d[1:0];
        reg_control:  r.control  = d[1:0];
        reg_scratch:  r.scratch  = d;
        default:      ; // read-only
      endcase
    end
    return r;
  endfunction

  function automatic boot_conf_e ref_boot(input logic cfg_dip0, input logic sys_cfg1);
    if (!cfg_dip0) begin
      return boot_fast;
    end
    return sys_cfg1 ? boot_eeprom : boot_fast;
  endfunction

  task automatic next_cycle();
    @(posedge clk_master);
    #1;
  endtask

  task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  task automatic wait_ready();
    do begin
      next_cycle();
    end while (!epb_rdy);
  endtask

  // release cs_n and let the bridge see it high before the next access
  task automatic end_access();
    next_cycle();
    epb_cs_n  = 1'b1;
    epb_we_n  = 1'b1;
    epb_oen_n = 1'b1;
    do begin
      next_cycle();
    end while (epb_rdy);
    repeat (2) next_cycle();
  endtask

  task automatic epb_write(input logic [4:0] adr, input logic [7:0] data);
    next_cycle();
    epb_addr  = adr;
    epb_wdata = data;
    epb_we_n  = 1'b0;
    epb_cs_n  = 1'b0;
    wait_ready();
    end_access();
    mdl = ref_write(mdl, adr, data);
  endtask

  task automatic epb_read(input logic [4:0] adr, input string name);
    next_cycle();
    epb_addr  = adr;
    epb_oen_n = 1'b0;
    epb_cs_n  = 1'b0;
    wait_ready();
    assert (epb_data_oe) else begin
      other_errs++;
      $display("data output enable is low while read data is ready at %0t", $time);
    end
    check(name, ref_read(adr, mdl), epb_rdata);
    end_access();
  endtask

  task automatic print_counts();
    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, val_errs, other_errs);
  endtask

  initial begin : compare
    string      nm;
    logic [7:0] ev;
    logic [7:0] av;
    forever begin
      @(posedge clk_master);
      while (exp_q.size() > 0) begin
        nm = name_q.pop_front();
        ev = exp_q.pop_front();
        av = act_q.pop_front();
        n_checks++;
        assert (av === ev) else begin
          val_errs++;
          $display("error %s: expected %02h actual %02h", nm, ev, av);
        end
      end
    end
  end

  initial begin : watchdog
    #((N_ACCESS * 40 + RESET_CYCLES) * CLK_PERIOD);
    $display("timeout: the run hung waiting for epb ready");
    print_counts();
    $display("Regression failed");
    $finish;
  end

  initial begin : stimulus
    logic [7:0] d;
    int i;
    int k;
    void'($urandom(32'hdb72));
    epb_cs_n      = 1'b1;
    epb_we_n      = 1'b1;
    epb_oen_n     = 1'b1;
    epb_addr      = '0;
    epb_wdata     = '0;
    reset_por_n   = 1'b1;
    reset_debug_n = 1'b1;
    v5c_done      = 1'b0;
    mdl           = '0;
    mdl.flash_busy_n = 1'b1;
    reset_mon     = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_master);
    #1;
    reset_mon = 1'b0;
    next_cycle();

    for (i = 0; i < 8; i++) begin
      epb_read({2'd3, 3'(i)}, "rev_bank");
    end

    for (k = 0; k < 4; k++) begin
      epb_write({2'd0, reg_scratch}, 8'($urandom));
      epb_read({2'd0, reg_scratch}, "rw_scratch");
      d = 8'($urandom);
      epb_write({2'd0, reg_user_led}, d);
      epb_read({2'd0, reg_user_led}, "rw_user_led");
      check("user_led_pins", {6'b0, ~d[1:0]}, {6'b0, user_led_n});
      epb_write({2'd0, reg_control}, 8'($urandom));
      epb_read({2'd0, reg_control}, "rw_control");
    end

    for (k = 0; k < 2; k++) begin
      next_cycle();
      mdl.sys_config   = 8'($urandom);
      mdl.user_dip     = 4'($urandom);
      mdl.config_dip   = 4'($urandom);
      mdl.flash_busy_n = 1'($urandom);
      mdl.syserr       = 1'($urandom);
      for (i = 2; i < 5; i++) begin
        epb_read({2'd0, 3'(i)}, "ro_read");
      end
      for (i = 2; i < 5; i++) begin
        epb_write({2'd0, 3'(i)}, 8'($urandom));
      end
      for (i = 2; i < 5; i++) begin
        epb_read({2'd0, 3'(i)}, "ro_write_ignored");
      end
      epb_write({2'd1, 3'd5}, 8'($urandom)); // aliases scratch offset
      epb_write({2'd2, 3'd0}, {6'($urandom), ~mdl.user_led}); // aliases user_led offset
      epb_read({2'd1, 3'd5}, "unmapped_bank");
      epb_read({2'd2, 3'd0}, "unmapped_bank");
      epb_read({2'd0, reg_scratch}, "unmapped_bank");
      epb_read({2'd0, reg_user_led}, "unmapped_bank");
    end

    epb_write({2'd0, reg_control}, 8'h02);
    check("geth_reset", 8'h00, {7'b0, geth_reset_n});
    epb_write({2'd0, reg_control}, 8'h00);
    check("geth_reset", 8'h01, {7'b0, geth_reset_n});
    reset_debug_n = 1'b0;
    next_cycle();
    check("ppc_reset", 8'h00, {7'b0, ppc_reset_n});
    reset_debug_n = 1'b1;
    next_cycle();
    check("ppc_reset", 8'h07, {5'b0, ppc_reset_n, ppc_ddr2_reset_n, geth_reset_n});
    reset_por_n = 1'b0; // also clears any por force left from random writes
    next_cycle();
    check("por_reset", 8'h00, {5'b0, ppc_reset_n, ppc_ddr2_reset_n, geth_reset_n});
    next_cycle();
    reset_por_n = 1'b1;
    next_cycle();

    epb_write({2'd0, reg_control}, 8'h00);
    check("por_force", 8'h00, {7'b0, por_force});
    epb_write({2'd0, reg_control}, 8'h01);
    check("por_force", 8'h01, {7'b0, por_force});
    epb_write({2'd0, reg_control}, 8'h00);
    check("por_force", 8'h01, {7'b0, por_force}); // sticky
    reset_por_n = 1'b0;
    repeat (2) next_cycle();
    reset_por_n = 1'b1;
    next_cycle();
    check("por_force", 8'h00, {7'b0, por_force});

    for (i = 0; i < 4; i++) begin
      mdl.config_dip = {3'($urandom), i[0]};
      mdl.sys_config = {6'($urandom), i[1], 1'($urandom)};
      next_cycle();
      check("boot_conf", {5'b0, ref_boot(i[0], i[1])}, {5'b0, boot_conf});
    end
    mdl.syserr = 1'b0;
    for (i = 0; i < 4; i++) begin
      mdl.flash_busy_n = i[0];
      v5c_done         = i[1];
      next_cycle();
      check("sys_led", {6'b0, ~{~i[0], i[1]}}, {6'b0, sys_led_n});
    end

    repeat (3) next_cycle(); // let the compare process drain
    other_errs += DUT.u_epb_bridge.u_sysctl_properties.fail_cnt;
    print_counts();
    if (val_errs == 0 && other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- tb/sysctl_properties.sv
`timescale 1ns/1ps

module sysctl_properties import sysctl_bus_pkg::*; (
  input logic          clk_master,
  input logic          reset_mon,
  input bridge_state_e state,
  input logic          stb,
  input logic          ack,
  input logic          cs_n_pin,
  input logic          oen_n_pin,
  input logic          data_oe
);

  int fail_cnt = 0; // assertion failures so far

  // a request never lasts longer than one cycle
  stb_single: assert property (@(posedge clk_master) disable iff (reset_mon)
    stb |=> !stb)
    else begin
      fail_cnt++;
      $error("bus stb high for two consecutive cycles");
    end

  // pads turn on only if cs_n and oen_n were low two synchroniser stages back
  oe_rise: assert property (@(posedge clk_master) disable iff (reset_mon)
    $rose(data_oe) |-> (!$past(cs_n_pin, 2) && !$past(oen_n_pin, 2)))
    else begin
      fail_cnt++;
      $error("epb data output enable rose outside a selected read");
    end

  ack_after_stb: assert property (@(posedge clk_master) disable iff (reset_mon)
    ack |-> ($past(stb) && state == wait_ack))
    else begin
      fail_cnt++;
      $error("bus ack without a preceding stb");
    end

endmodule

bind epb_bridge sysctl_properties u_sysctl_properties (
  .clk_master (clk_master),
  .reset_mon  (reset_mon),
  .state      (state),
  .stb        (bus.stb),
  .ack        (bus.ack),
  .cs_n_pin   (epb_cs_n_i),
  .oen_n_pin  (epb_oen_n_i),
  .data_oe    (epb_data_oe_o)
);

//--- design/sysctl_top.sv
`timescale 1ns/1ps

module sysctl_top import sysctl_bus_pkg::*; (
  input  logic                 clk_master,
  input  logic                 reset_mon,
  input  logic                 epb_cs_n_i,
  input  logic                 epb_we_n_i,
  input  logic                 epb_oen_n_i,
  input  logic [SYSCTL_AW-1:0] epb_addr_i,
  input  logic [SYSCTL_DW-1:0] epb_data_i,
  output logic [SYSCTL_DW-1:0] epb_data_o,
  output logic                 epb_data_oe_o,
  output logic                 epb_rdy_o,
  input  logic                 reset_por_n_i,
  input  logic                 reset_debug_n_i,
  input  logic [7:0]           sys_config_i,
  input  logic [3:0]           user_dip_i,
  input  logic [3:0]           config_dip_i,
  input  logic                 flash_busy_n_i,
  input  logic                 ppc_syserr_i,
  input  logic                 v5c_done_i,
  output logic                 ppc_reset_n_o,
  output logic                 ppc_ddr2_reset_n_o,
  output logic                 geth_reset_n_o,
  output logic                 por_force_o,
  output logic [1:0]           sys_led_n_o,
  output logic [1:0]           user_led_n_o,
  output logic [2:0]           boot_conf_o
);

  logic [1:0] user_led;
  logic       por_force_req;
  logic       geth_reset_req;

  sysctl_bus_if bus ();

  epb_bridge u_epb_bridge (
    .clk_master    (clk_master),
    .reset_mon     (reset_mon),
    .epb_cs_n_i    (epb_cs_n_i),
    .epb_we_n_i    (epb_we_n_i),
    .epb_oen_n_i   (epb_oen_n_i),
    .epb_addr_i    (epb_addr_i),
    .epb_data_i    (epb_data_i),
    .epb_data_o    (epb_data_o),
    .epb_data_oe_o (epb_data_oe_o),
    .epb_rdy_o     (epb_rdy_o),
    .bus           (bus.bridge)
  );

  sysctl_regs u_sysctl_regs (
    .clk_master       (clk_master),
    .reset_mon        (reset_mon),
    .sys_config_i     (sys_config_i),
    .user_dip_i       (user_dip_i),
    .config_dip_i     (config_dip_i),
    .flash_busy_n_i   (flash_busy_n_i),
    .ppc_syserr_i     (ppc_syserr_i),
    .user_led_o       (user_led),
    .por_force_req_o  (por_force_req),
    .geth_reset_req_o (geth_reset_req),
    .bus              (bus.regs)
  );

  reset_led_ctrl u_reset_led_ctrl (
    .clk_master         (clk_master),
    .reset_mon          (reset_mon),
    .reset_por_n_i      (reset_por_n_i),
    .reset_debug_n_i    (reset_debug_n_i),
    .flash_busy_n_i     (flash_busy_n_i),
    .ppc_syserr_i       (ppc_syserr_i),
    .v5c_done_i         (v5c_done_i),
    .config_dip_i       (config_dip_i),
    .sys_config_i       (sys_config_i),
    .user_led_i         (user_led),
    .por_force_req_i    (por_force_req),
    .geth_reset_req_i   (geth_reset_req),
    .ppc_reset_n_o      (ppc_reset_n_o),
    .ppc_ddr2_reset_n_o (ppc_ddr2_reset_n_o),
    .geth_reset_n_o     (geth_reset_n_o),
    .por_force_o        (por_force_o),
    .sys_led_n_o        (sys_led_n_o),
    .user_led_n_o       (user_led_n_o),
    .boot_conf_o        (boot_conf_o)
  );

endmodule

//--- design/reset_led_ctrl.sv
`timescale 1ns/1ps
`include "sysctl_macros.svh"

module reset_led_ctrl import sysctl_board_pkg::*; (
  input  logic       clk_master,
  input  logic       reset_mon,
  input  logic       reset_por_n_i,
  input  logic       reset_debug_n_i,
  input  logic       flash_busy_n_i,
  input  logic       ppc_syserr_i,
  input  logic       v5c_done_i,
  input  logic [3:0] config_dip_i,
  input  logic [7:0] sys_config_i,
  input  logic [1:0] user_led_i,
  input  logic       por_force_req_i,
  input  logic       geth_reset_req_i,
  output logic       ppc_reset_n_o,
  output logic       ppc_ddr2_reset_n_o,
  output logic       geth_reset_n_o,
  output logic       por_force_o,
  output logic [1:0] sys_led_n_o,
  output logic [1:0] user_led_n_o,
  output logic [2:0] boot_conf_o
);

  localparam int CNT_W = `SYSCTL_BLINK_BIT + 1;

  logic             sys_reset;
  logic             por_req_d;
  logic             por_force_q;
  logic [CNT_W-1:0] blink_cnt;
  boot_conf_e       boot_sel;

  assign sys_reset = reset_mon || !reset_por_n_i;

  assign ppc_reset_n_o      = reset_debug_n_i && !sys_reset;
  assign ppc_ddr2_reset_n_o = !sys_reset;
  assign geth_reset_n_o     = !sys_reset && !geth_reset_req_i; // software can hold the phy

  // por force latches on the request edge and only a system reset drops it
  always_ff @(posedge clk_master) begin
    por_req_d <= por_force_req_i;
    if (sys_reset) begin
      por_force_q <= 1'b0;
    end else if (por_force_req_i && !por_req_d) begin
      por_force_q <= 1'b1;
    end
  end

  assign por_force_o = por_force_q;

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      blink_cnt <= '0;
    end else begin
      blink_cnt <= blink_cnt + 1'b1;
    end
  end

  // led 1 shows flash busy, led 0 blinks on syserr else shows config done
  assign sys_led_n_o  = ~{!flash_busy_n_i,
                          ppc_syserr_i ? blink_cnt[`SYSCTL_BLINK_BIT] : v5c_done_i};
  assign user_led_n_o = ~user_led_i;

  always_comb begin
    if (!config_dip_i[0]) begin
      boot_sel = boot_fast;
    end else if (sys_config_i[1]) begin
      boot_sel = boot_eeprom;
    end else begin
      boot_sel = boot_fast;
    end
  end

  assign boot_conf_o = boot_sel;

endmodule

//--- design/sysctl_regs.sv
`timescale 1ns/1ps
`include "sysctl_macros.svh"

module sysctl_regs import sysctl_bus_pkg::*, sysctl_board_pkg::*; (
  input  logic       clk_master,
  input  logic       reset_mon,
  input  logic [7:0] sys_config_i,
  input  logic [3:0] user_dip_i,
  input  logic [3:0] config_dip_i,
  input  logic       flash_busy_n_i,
  input  logic       ppc_syserr_i,
  output logic [1:0] user_led_o,
  output logic       por_force_req_o,
  output logic       geth_reset_req_o,
  sysctl_bus_if.regs bus
);

  localparam logic [1:0] BANK_MISC = 2'd0;
  localparam logic [1:0] BANK_REV  = 2'd3; // banks 1 and 2 are unmapped

  localparam logic [15:0] REV_ID  = `SYSCTL_DESIGN_ID;
  localparam logic [7:0]  REV_MAJ = `SYSCTL_REV_MAJOR;
  localparam logic [7:0]  REV_MIN = `SYSCTL_REV_MINOR;
  localparam logic [15:0] REV_RCS = `SYSCTL_REV_RCS;

  logic [1:0]           bank;
  reg_idx_e             idx;
  logic [SYSCTL_DW-1:0] misc_rdat;
  logic [SYSCTL_DW-1:0] rev_rdat;
  logic [SYSCTL_DW-1:0] rd_mux;
  logic                 wr_misc;

  logic [1:0]           user_led_q;
  logic [1:0]           control_q;
  logic [SYSCTL_DW-1:0] scratch_q;
  logic                 ack_q;
  logic [SYSCTL_DW-1:0] rdat_q;

  assign bank = bus.adr[4:3];
  assign idx  = reg_idx_e'(bus.adr[2:0]);

  // misc bank read values, read-only entries are live inputs
  always_comb begin
    case (idx)
      reg_user_led:   misc_rdat = {6'b0, user_led_q};
      reg_control:    misc_rdat = {6'b0, control_q};
      reg_sys_config: misc_rdat = sys_config_i;
      reg_dips:       misc_rdat = {user_dip_i, config_dip_i};
      reg_status:     misc_rdat = {6'b0, ppc_syserr_i, !flash_busy_n_i};
      reg_scratch:    misc_rdat = scratch_q;
      default:        misc_rdat = '0;
    endcase
  end

  always_comb begin
    case (bus.adr[2:0])
      3'd0:    rev_rdat = REV_ID[15:8];
      3'd1:    rev_rdat = REV_ID[7:0];
      3'd2:    rev_rdat = REV_MAJ;
      3'd3:    rev_rdat = REV_MIN;
      3'd4:    rev_rdat = REV_RCS[15:8];
      3'd5:    rev_rdat = REV_RCS[7:0];
      default: rev_rdat = '0;
    endcase
  end

  assign rd_mux = (bank == BANK_MISC) ? misc_rdat :
                  (bank == BANK_REV)  ? rev_rdat  :
                                        '0;

  assign wr_misc = bus.stb && (bus.op == op_write) && (bank == BANK_MISC);

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      user_led_q <= '0;
      control_q  <= '0;
      scratch_q  <= '0;
      ack_q      <= 1'b0;
    end else begin
      ack_q <= bus.stb; // every access is answered, mapped or not
      if (wr_misc) begin
        case (idx)
          reg_user_led: user_led_q <= bus.wdat[1:0];
          reg_control:  control_q  <= bus.wdat[1:0];
          reg_scratch:  scratch_q  <= bus.wdat;
          default:      ; // read-only offset
        endcase
      end
    end
  end

  always_ff @(posedge clk_master) begin
    if (bus.stb) begin
      rdat_q <= rd_mux;
    end
  end

  assign bus.ack  = ack_q;
  assign bus.rdat = rdat_q;

  assign user_led_o       = user_led_q;
  assign por_force_req_o  = control_q[0];
  assign geth_reset_req_o = control_q[1];

endmodule

//--- design/epb_bridge.sv
`timescale 1ns/1ps

module epb_bridge import sysctl_bus_pkg::*; (
  input  logic                 clk_master,
  input  logic                 reset_mon,
  input  logic                 epb_cs_n_i,
  input  logic                 epb_we_n_i,
  input  logic                 epb_oen_n_i,
  input  logic [SYSCTL_AW-1:0] epb_addr_i,
  input  logic [SYSCTL_DW-1:0] epb_data_i,
  output logic [SYSCTL_DW-1:0] epb_data_o,
  output logic                 epb_data_oe_o,
  output logic                 epb_rdy_o,
  sysctl_bus_if.bridge         bus
);

  logic [2:0] strb_meta; // {cs_n, we_n, oen_n}, first stage
  logic [2:0] strb_sync; // second stage
  logic       cs_n_s;
  logic       we_n_s;
  logic       oen_n_s;
  logic       cs_n_prev;
  logic       cs_fall;

  bridge_state_e        state;
  bridge_state_e        state_nxt;
  bus_op_e              op_q;
  logic [SYSCTL_AW-1:0] adr_q;
  logic [SYSCTL_DW-1:0] wdat_q;
  logic [SYSCTL_DW-1:0] rdat_q;

  assign cs_n_s  = strb_sync[2];
  assign we_n_s  = strb_sync[1];
  assign oen_n_s = strb_sync[0];
  assign cs_fall = cs_n_prev && !cs_n_s;

  // strobes come from the host bus clock, two flops each
  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      strb_meta <= 3'b111;
      strb_sync <= 3'b111;
      cs_n_prev <= 1'b1;
      state     <= idle;
    end else begin
      strb_meta <= {epb_cs_n_i, epb_we_n_i, epb_oen_n_i};
      strb_sync <= strb_meta;
      cs_n_prev <= cs_n_s;
      state     <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      idle:     if (cs_fall) state_nxt = access;
      access:   state_nxt = wait_ack;
      wait_ack: if (bus.ack) state_nxt = hold;
      hold:     if (cs_n_s) state_nxt = idle; // host released chip select
      default:  state_nxt = idle;
    endcase
  end

  // address and data are stable by the time cs_n has crossed over
  always_ff @(posedge clk_master) begin
    if (state == idle && cs_fall) begin
      adr_q  <= epb_addr_i;
      wdat_q <= epb_data_i;
      op_q   <= we_n_s ? op_read : op_write;
    end
    if (state == wait_ack && bus.ack) begin
      rdat_q <= bus.rdat; // held for the rest of the access
    end
  end

  assign bus.stb  = (state == access);
  assign bus.op   = op_q;
  assign bus.adr  = adr_q;
  assign bus.wdat = wdat_q;

  assign epb_rdy_o     = (state == hold);
  assign epb_data_o    = rdat_q;
  // drive the pads only for a read the host is still selecting
  assign epb_data_oe_o = epb_rdy_o && (op_q == op_read) && !cs_n_s && !oen_n_s;

endmodule

//--- design/sysctl_bus_if.sv
`timescale 1ns/1ps

interface sysctl_bus_if import sysctl_bus_pkg::*; ();

  logic                 stb;  // one-cycle request
  bus_op_e              op;
  logic [SYSCTL_AW-1:0] adr;
  logic [SYSCTL_DW-1:0] wdat;
  logic [SYSCTL_DW-1:0] rdat; // valid with ack
  logic                 ack;  // one cycle after stb

  modport bridge (
    output stb, op, adr, wdat,
    input  rdat, ack
  );

  modport regs (
    input  stb, op, adr, wdat,
    output rdat, ack
  );

endinterface

//--- design/sysctl_board_pkg.sv
package sysctl_board_pkg;

  // offsets inside the miscellaneous bank
  typedef enum logic [2:0] {
    reg_user_led   = 3'd0, // r/w, 2 bits
    reg_control    = 3'd1, // r/w, bit0 por_force, bit1 geth_reset
    reg_sys_config = 3'd2, // ro
    reg_dips       = 3'd3, // ro, {user_dip, config_dip}
    reg_status     = 3'd4, // ro, bit0 flash busy, bit1 syserr
    reg_scratch    = 3'd5  // r/w, 8 bits
  } reg_idx_e;

  // codes presented on the processor boot pins
  typedef enum logic [2:0] {
    boot_fast   = 3'b010,
    boot_eeprom = 3'b111  // i2c boot from eeprom
  } boot_conf_e;

endpackage

//--- design/sysctl_bus_pkg.sv
package sysctl_bus_pkg;

  // register bus geometry
  localparam int SYSCTL_AW = 5; // bits 4:3 pick the bank, 2:0 the offset
  localparam int SYSCTL_DW = 8;

  // bridge sequencing, one bus access per chip-select period
  typedef enum logic [1:0] {
    idle     = 2'd0, // waiting for cs_n to fall
    access   = 2'd1, // stb cycle
    wait_ack = 2'd2, // register map answering
    hold     = 2'd3  // rdy high until cs_n released
  } bridge_state_e;

  // access direction on the internal bus
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } bus_op_e;

endpackage

//--- design/sysctl_macros.svh
`ifndef SYSCTL_MACROS_SVH
`define SYSCTL_MACROS_SVH

// revision bank contents
`define SYSCTL_DESIGN_ID 16'h0ac5
`define SYSCTL_REV_MAJOR 8'h02
`define SYSCTL_REV_MINOR 8'h07
`define SYSCTL_REV_RCS   16'h1b3e

// counter bit driving the error blink, roughly 2 Hz at the board clock
`define SYSCTL_BLINK_BIT 23

`endif
